/* list.f */
+incdir+tb
hdl/fu_pkg.sv
hdl/alu.sv
hdl/issue_queue.sv
hdl/operand_read.sv
hdl/result_stage.sv
hdl/binary_func_unit.sv
tb/tb_func_unit.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the functional unit simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_func_unit -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_func_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    echo "No result line found in sim.log"
    exit 1
fi
exit 0

/* tb/tb_func_unit_model.svh */
// Functional unit reference model
`ifndef TB_FUNC_UNIT_MODEL_SVH
`define TB_FUNC_UNIT_MODEL_SVH

// Expected result of one instruction from its opcode rule
function automatic fu_pkg::reg_val_t calc_result(input fu_pkg::op_t op,
                                                 input fu_pkg::reg_val_t a,
                                                 input fu_pkg::reg_val_t b,
                                                 input fu_pkg::imm_t imm);
    logic [31:0] prod;
    prod = {16'd0, a} * {16'd0, b};
    case (op)
        fu_pkg::OP_ST:      return b;
        fu_pkg::OP_CMP_GT:  return (a > b) ? 16'd1 : 16'd0;
        fu_pkg::OP_ADD_IMM: return a + {12'd0, imm};
        fu_pkg::OP_ADD:     return a + b;
        fu_pkg::OP_SHL:     return (b >= 16'd16) ? 16'd0 : a << b[3:0];
        fu_pkg::OP_SHR:     return (b >= 16'd16) ? 16'd0 : a >> b[3:0];
        fu_pkg::OP_MUL:     return prod[15:0];
        default:            return 16'd0;
    endcase
endfunction

// Linear congruential generator step
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

task automatic check_inst_id(input fu_pkg::inst_id_t got, input fu_pkg::inst_id_t exp,
                             input string what);
    if (got !== exp) begin
        errors++;
        $display("FAIL %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
endtask

task automatic check_reg_id(input fu_pkg::reg_id_t got, input fu_pkg::reg_id_t exp,
                            input string what);
    if (got !== exp) begin
        errors++;
        $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_reg_val(input fu_pkg::reg_val_t got, input fu_pkg::reg_val_t exp,
                             input string what);
    if (got !== exp) begin
        errors++;
        $display("FAIL %0t: %s got %04h expected %04h", $time, what, got, exp);
    end
endtask

task automatic check_mask(input fu_pkg::reg_mask_t got, input fu_pkg::reg_mask_t exp,
                          input string what);
    if (got !== exp) begin
        errors++;
        $display("FAIL %0t: %s got %02h expected %02h", $time, what, got, exp);
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        errors++;
        $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
    end
endtask

`endif

/* tb/tb_func_unit.sv */
// Functional unit testbench
`default_nettype none

module tb_func_unit;

    logic clk;
    logic rst_n;
    logic issue_vld;
    logic issue_rdy;
    fu_pkg::inst_id_t issue_id;
    fu_pkg::op_t issue_op;
    fu_pkg::reg_id_t issue_dst_reg;
    fu_pkg::reg_id_t issue_src_reg0;
    fu_pkg::reg_id_t issue_src_reg1;
    fu_pkg::imm_t issue_imm;
    fu_pkg::reg_mask_t pending_read_mask;
    logic read_req_vld;
    logic read_req_rdy;
    fu_pkg::reg_id_t read_reg0_id;
    fu_pkg::reg_id_t read_reg1_id;
    fu_pkg::reg_id_t write_reg_id_nxt;
    logic read_fbk_vld;
    logic read_fbk_rdy;
    fu_pkg::reg_val_t read_reg0_val;
    fu_pkg::reg_val_t read_reg1_val;
    logic write_back_vld;
    logic write_back_rdy;
    fu_pkg::inst_id_t write_back_id;
    fu_pkg::reg_id_t write_back_reg_id;
    fu_pkg::reg_val_t write_back_addr;
    fu_pkg::reg_val_t write_back_val;
    logic idle;

    logic [31:0] lcg_state = 32'h6128;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    bit run_done = 0;

    // Register file contents and test modes
    fu_pkg::reg_val_t regs [fu_pkg::NUM_REG];
    bit req_random;
    bit fbk_hold;
    int wb_mode;
    fu_pkg::inst_id_t next_id;

    // Issued instructions still waiting for their read request
    fu_pkg::reg_id_t iss_src0_q[$];
    fu_pkg::reg_id_t iss_src1_q[$];
    fu_pkg::reg_id_t iss_dst_q[$];

    // Outstanding reads and expected write-backs, both in order
    fu_pkg::reg_id_t req_s0_q[$];
    fu_pkg::reg_id_t req_s1_q[$];
    int req_delay_q[$];
    fu_pkg::inst_id_t exp_id_q[$];
    fu_pkg::reg_id_t exp_reg_q[$];
    fu_pkg::reg_val_t exp_addr_q[$];
    fu_pkg::reg_val_t exp_val_q[$];

    `include "tb_func_unit_model.svh"

    binary_func_unit binary_func_unit_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Register file side, recorded at the rising edge
    always @(posedge clk) begin
        logic [31:0] r;
        if (rst_n && read_req_vld && read_req_rdy) begin
            r = lcg_next();
            if (iss_dst_q.size() == 0) begin
                errors++;
                $display("Read request arrived with no instruction waiting for it");
            end else begin
                check_reg_id(read_reg0_id, iss_src0_q.pop_front(), "read request src0");
                check_reg_id(read_reg1_id, iss_src1_q.pop_front(), "read request src1");
                check_reg_id(write_reg_id_nxt, iss_dst_q.pop_front(), "read request dst");
            end
            req_s0_q.push_back(read_reg0_id);
            req_s1_q.push_back(read_reg1_id);
            req_delay_q.push_back(int'(r[17:16]));
        end
        if (rst_n && read_fbk_vld && read_fbk_rdy) begin
            void'(req_s0_q.pop_front());
            void'(req_s1_q.pop_front());
            void'(req_delay_q.pop_front());
        end
    end

    // Write-back checker
    always @(posedge clk) begin
        if (rst_n && write_back_vld && write_back_rdy) begin
            if (exp_id_q.size() == 0) begin
                errors++;
                $display("Write-back of id %0h arrived with nothing expected", write_back_id);
            end else begin
                check_inst_id(write_back_id, exp_id_q.pop_front(), "write-back id");
                check_reg_id(write_back_reg_id, exp_reg_q.pop_front(), "write-back reg");
                check_reg_val(write_back_addr, exp_addr_q.pop_front(), "write-back addr");
                check_reg_val(write_back_val, exp_val_q.pop_front(), "write-back value");
            end
        end
    end

    // Register file and write-back ready drivers
    always @(negedge clk) begin
        logic [31:0] r;
        r = lcg_next();
        read_req_rdy = req_random ? r[20] : 1'b1;
        case (wb_mode)
            1:       write_back_rdy = r[24] | r[25];
            2:       write_back_rdy = 1'b0;
            default: write_back_rdy = 1'b1;
        endcase
        read_fbk_vld = 1'b0;
        if (!fbk_hold && req_s0_q.size() > 0) begin
            if (req_delay_q[0] == 0) begin
                read_fbk_vld  = 1'b1;
                read_reg0_val = regs[req_s0_q[0]];
                read_reg1_val = regs[req_s1_q[0]];
            end else begin
                req_delay_q[0] = req_delay_q[0] - 1;
            end
        end
    end

    task automatic finish_run();
        if (!run_done) begin
            run_done = 1;
            $display("Tests run %0d, tests failed %0d, errors %0d",
                     tests_run, tests_failed, errors);
            if (errors == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    endtask

    task automatic abort_on_timeout(input string what);
        errors++;
        $display("Timed out while waiting for %s", what);
        finish_run();
    endtask

    // Offers one instruction and reports whether it was taken
    task automatic try_issue(input fu_pkg::op_t op, input fu_pkg::reg_id_t s0,
                             input fu_pkg::reg_id_t s1, input fu_pkg::imm_t imm,
                             input int limit, output bit accepted);
        int cycles;
        accepted = 0;
        cycles = 0;
        issue_id = next_id;
        issue_op = op;
        issue_dst_reg = next_id[2:0];
        issue_src_reg0 = s0;
        issue_src_reg1 = s1;
        issue_imm = imm;
        issue_vld = 1'b1;
        while (!accepted && cycles < limit) begin
            @(posedge clk);
            accepted = issue_rdy;
            cycles++;
        end
        if (accepted) begin
            iss_src0_q.push_back(s0);
            iss_src1_q.push_back(s1);
            iss_dst_q.push_back(next_id[2:0]);
            exp_id_q.push_back(next_id);
            exp_reg_q.push_back(next_id[2:0]);
            exp_addr_q.push_back(regs[s0]);
            exp_val_q.push_back(calc_result(op, regs[s0], regs[s1], imm));
            next_id = next_id + 8'd1;
        end
        @(negedge clk);
        issue_vld = 1'b0;
    endtask

    task automatic issue_inst(input fu_pkg::op_t op, input fu_pkg::reg_id_t s0,
                              input fu_pkg::reg_id_t s1, input fu_pkg::imm_t imm);
        bit accepted;
        try_issue(op, s0, s1, imm, 200, accepted);
        if (!accepted) begin
            abort_on_timeout("issue_rdy");
        end
    endtask

    // Waits until every issued instruction has been written back
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (!(exp_id_q.size() == 0 && req_s0_q.size() == 0) && cycles < 5000) begin
            @(negedge clk);
            cycles++;
        end
        if (!(exp_id_q.size() == 0 && req_s0_q.size() == 0)) begin
            abort_on_timeout("the unit to drain");
        end
    endtask

    task automatic wait_read_requests(input int num);
        int cycles;
        cycles = 0;
        while (req_s0_q.size() < num && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (req_s0_q.size() < num) begin
            abort_on_timeout("a read request");
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %0d %s: PASS", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAIL", tests_run, name);
        end
    endtask

    initial begin
        int errs;
        bit accepted;
        logic [31:0] r;
        rst_n = 1'b0;
        issue_vld = 1'b0;
        issue_id = '0;
        issue_op = '0;
        issue_dst_reg = '0;
        issue_src_reg0 = '0;
        issue_src_reg1 = '0;
        issue_imm = '0;
        read_req_rdy = 1'b0;
        read_fbk_vld = 1'b0;
        read_reg0_val = '0;
        read_reg1_val = '0;
        write_back_rdy = 1'b0;
        req_random = 0;
        fbk_hold = 0;
        wb_mode = 0;
        next_id = '0;
        regs = '{16'h1234, 16'd16, 16'd20, 16'd3, 16'h1234, 16'h00f0, 16'hffff, 16'd5};
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        errs = errors;
        check_flag(idle, 1'b1, "idle after reset");
        check_flag(issue_rdy, 1'b1, "issue_rdy after reset");
        check_mask(pending_read_mask, '0, "pending mask after reset");
        check_flag(read_req_vld, 1'b0, "read_req_vld after reset");
        check_flag(read_fbk_rdy, 1'b0, "read_fbk_rdy after reset");
        check_flag(write_back_vld, 1'b0, "write_back_vld after reset");
        report_test("reset state", errs);

        // One of each opcode plus shift and compare edges
        errs = errors;
        issue_inst(fu_pkg::OP_ST, 0, 5, 0);
        issue_inst(fu_pkg::OP_CMP_GT, 0, 4, 0);
        issue_inst(fu_pkg::OP_CMP_GT, 6, 5, 0);
        issue_inst(fu_pkg::OP_ADD_IMM, 6, 0, 4'hf);
        issue_inst(fu_pkg::OP_ADD, 0, 6, 0);
        issue_inst(fu_pkg::OP_SHL, 0, 3, 0);
        issue_inst(fu_pkg::OP_SHL, 0, 1, 0);
        issue_inst(fu_pkg::OP_SHR, 6, 2, 0);
        issue_inst(fu_pkg::OP_SHR, 5, 7, 0);
        issue_inst(fu_pkg::OP_MUL, 0, 6, 0);
        wait_drain();
        report_test("directed opcodes", errs);

        // Random traffic with throttling on every handshake
        errs = errors;
        for (int i = 0; i < fu_pkg::NUM_REG; i++) begin
            r = lcg_next();
            regs[i] = (i < 4) ? {11'd0, r[20:16]} : r[31:16];
        end
        req_random = 1;
        wb_mode = 1;
        for (int i = 0; i < 300; i++) begin
            r = lcg_next();
            issue_inst(r[18:16], r[21:19], r[24:22], r[28:25]);
        end
        wait_drain();
        req_random = 0;
        wb_mode = 0;
        report_test("random traffic", errs);

        // Back-pressure fills the unit with six instructions
        errs = errors;
        wb_mode = 2;
        for (int i = 0; i < 6; i++) begin
            issue_inst(fu_pkg::OP_ADD, i[2:0], 3'd7, 0);
        end
        try_issue(fu_pkg::OP_ADD, 1, 2, 0, 20, accepted);
        if (accepted) begin
            errors++;
            $display("A seventh instruction was accepted while the unit was full");
        end
        check_flag(issue_rdy, 1'b0, "issue_rdy while full");
        check_flag(read_fbk_rdy, 1'b0, "read_fbk_rdy while full");
        wb_mode = 0;
        wait_drain();
        report_test("back-pressure", errs);

        // Pending reads while feedback is withheld
        errs = errors;
        fbk_hold = 1;
        issue_inst(fu_pkg::OP_ADD, 1, 2, 0);
        issue_inst(fu_pkg::OP_ADD, 3, 3, 0);
        issue_inst(fu_pkg::OP_ADD, 5, 0, 0);
        wait_read_requests(1);
        check_mask(pending_read_mask, 8'b0010_1111, "pending mask with feedback held");
        fbk_hold = 0;
        wait_drain();
        check_mask(pending_read_mask, '0, "pending mask after drain");
        check_flag(idle, 1'b1, "idle after drain");
        report_test("pending reads", errs);

        finish_run();
    end

endmodule

`default_nettype wire

/* hdl/binary_func_unit.sv */
// Binary functional unit top
`default_nettype none

module binary_func_unit (
    input  wire                    clk,
    input  wire                    rst_n,

    input  wire                    issue_vld,
    output wire                    issue_rdy,
    input  wire fu_pkg::inst_id_t  issue_id,
    input  wire fu_pkg::op_t       issue_op,
    input  wire fu_pkg::reg_id_t   issue_dst_reg,
    input  wire fu_pkg::reg_id_t   issue_src_reg0,
    input  wire fu_pkg::reg_id_t   issue_src_reg1,
    input  wire fu_pkg::imm_t      issue_imm,

    output wire fu_pkg::reg_mask_t pending_read_mask,

    output wire                    read_req_vld,
    input  wire                    read_req_rdy,
    output wire fu_pkg::reg_id_t   read_reg0_id,
    output wire fu_pkg::reg_id_t   read_reg1_id,
    output wire fu_pkg::reg_id_t   write_reg_id_nxt,

    input  wire                    read_fbk_vld,
    output wire                    read_fbk_rdy,
    input  wire fu_pkg::reg_val_t  read_reg0_val,
    input  wire fu_pkg::reg_val_t  read_reg1_val,

    output wire                    write_back_vld,
    input  wire                    write_back_rdy,
    output wire fu_pkg::inst_id_t  write_back_id,
    output wire fu_pkg::reg_id_t   write_back_reg_id,
    output wire fu_pkg::reg_val_t  write_back_addr,
    output wire fu_pkg::reg_val_t  write_back_val,

    output wire                    idle
);

    // Queue head toward the read stage
    logic              head_vld;
    logic              head_rdy;
    fu_pkg::inst_id_t  head_id;
    fu_pkg::op_t       head_op;
    fu_pkg::reg_id_t   head_dst_reg;
    fu_pkg::reg_id_t   head_src_reg0;
    fu_pkg::reg_id_t   head_src_reg1;
    fu_pkg::imm_t      head_imm;
    fu_pkg::reg_mask_t queue_pending_read;
    logic              queue_empty;

    // Executed result toward write-back
    logic              exec_vld;
    logic              exec_rdy;
    fu_pkg::inst_id_t  exec_id;
    fu_pkg::reg_id_t   exec_dst_reg;
    fu_pkg::reg_val_t  exec_addr;
    fu_pkg::reg_val_t  exec_val;

    logic              read_busy;
    logic              result_busy;

    issue_queue issue_queue_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_vld        (issue_vld),
        .in_rdy        (issue_rdy),
        .in_id         (issue_id),
        .in_op         (issue_op),
        .in_dst_reg    (issue_dst_reg),
        .in_src_reg0   (issue_src_reg0),
        .in_src_reg1   (issue_src_reg1),
        .in_imm        (issue_imm),
        .head_vld      (head_vld),
        .head_rdy      (head_rdy),
        .head_id       (head_id),
        .head_op       (head_op),
        .head_dst_reg  (head_dst_reg),
        .head_src_reg0 (head_src_reg0),
        .head_src_reg1 (head_src_reg1),
        .head_imm      (head_imm),
        .pending_read  (queue_pending_read),
        .empty         (queue_empty)
    );

    operand_read operand_read_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .head_vld           (head_vld),
        .head_rdy           (head_rdy),
        .head_id            (head_id),
        .head_op            (head_op),
        .head_dst_reg       (head_dst_reg),
        .head_src_reg0      (head_src_reg0),
        .head_src_reg1      (head_src_reg1),
        .head_imm           (head_imm),
        .queue_pending_read (queue_pending_read),
        .pending_read_mask  (pending_read_mask),
        .read_req_vld       (read_req_vld),
        .read_req_rdy       (read_req_rdy),
        .read_reg0_id       (read_reg0_id),
        .read_reg1_id       (read_reg1_id),
        .write_reg_id_nxt   (write_reg_id_nxt),
        .read_fbk_vld       (read_fbk_vld),
        .read_fbk_rdy       (read_fbk_rdy),
        .read_reg0_val      (read_reg0_val),
        .read_reg1_val      (read_reg1_val),
        .exec_vld           (exec_vld),
        .exec_rdy           (exec_rdy),
        .exec_id            (exec_id),
        .exec_dst_reg       (exec_dst_reg),
        .exec_addr          (exec_addr),
        .exec_val           (exec_val),
        .busy               (read_busy)
    );

    result_stage result_stage_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .exec_vld          (exec_vld),
        .exec_rdy          (exec_rdy),
        .exec_id           (exec_id),
        .exec_dst_reg      (exec_dst_reg),
        .exec_addr         (exec_addr),
        .exec_val          (exec_val),
        .write_back_vld    (write_back_vld),
        .write_back_rdy    (write_back_rdy),
        .write_back_id     (write_back_id),
        .write_back_reg_id (write_back_reg_id),
        .write_back_addr   (write_back_addr),
        .write_back_val    (write_back_val),
        .busy              (result_busy)
    );

    // Nothing held anywhere in the unit
    assign idle = queue_empty && !read_busy && !result_busy;

endmodule

`default_nettype wire

/* hdl/result_stage.sv */
// Write-back holding register
`default_nettype none

module result_stage (
    input  wire                   clk,
    input  wire                   rst_n,

    input  wire                   exec_vld,
    output logic                  exec_rdy,
    input  wire fu_pkg::inst_id_t exec_id,
    input  wire fu_pkg::reg_id_t  exec_dst_reg,
    input  wire fu_pkg::reg_val_t exec_addr,
    input  wire fu_pkg::reg_val_t exec_val,

    output logic                  write_back_vld,
    input  wire                   write_back_rdy,
    output fu_pkg::inst_id_t      write_back_id,
    output fu_pkg::reg_id_t       write_back_reg_id,
    output fu_pkg::reg_val_t      write_back_addr,
    output fu_pkg::reg_val_t      write_back_val,

    output logic                  busy
);

    logic in_xfer;
    logic out_xfer;

    // Accept when empty or when the current result leaves this cycle
    assign exec_rdy = !write_back_vld || write_back_rdy;
    assign in_xfer  = exec_vld && exec_rdy;
    assign out_xfer = write_back_vld && write_back_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_back_vld <= 1'b0;
        end else if (in_xfer) begin
            write_back_vld <= 1'b1;
        end else if (out_xfer) begin
            write_back_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer) begin
            write_back_id     <= exec_id;
            write_back_reg_id <= exec_dst_reg;
            write_back_addr   <= exec_addr;
            write_back_val    <= exec_val;
        end
    end

    assign busy = write_back_vld;

endmodule

`default_nettype wire

/* hdl/operand_read.sv */
// Operand read stage
`default_nettype none

module operand_read (
    input  wire                    clk,
    input  wire                    rst_n,

    input  wire                    head_vld,
    output logic                   head_rdy,
    input  wire fu_pkg::inst_id_t  head_id,
    input  wire fu_pkg::op_t       head_op,
    input  wire fu_pkg::reg_id_t   head_dst_reg,
    input  wire fu_pkg::reg_id_t   head_src_reg0,
    input  wire fu_pkg::reg_id_t   head_src_reg1,
    input  wire fu_pkg::imm_t      head_imm,

    input  wire fu_pkg::reg_mask_t queue_pending_read,
    output fu_pkg::reg_mask_t      pending_read_mask,

    output logic                   read_req_vld,
    input  wire                    read_req_rdy,
    output fu_pkg::reg_id_t        read_reg0_id,
    output fu_pkg::reg_id_t        read_reg1_id,
    output fu_pkg::reg_id_t        write_reg_id_nxt,

    input  wire                    read_fbk_vld,
    output logic                   read_fbk_rdy,
    input  wire fu_pkg::reg_val_t  read_reg0_val,
    input  wire fu_pkg::reg_val_t  read_reg1_val,

    output logic                   exec_vld,
    input  wire                    exec_rdy,
    output fu_pkg::inst_id_t       exec_id,
    output fu_pkg::reg_id_t        exec_dst_reg,
    output fu_pkg::reg_val_t       exec_addr,
    output fu_pkg::reg_val_t       exec_val,

    output logic                   busy
);

    logic              stage_vld;
    logic              stage_free;
    logic              req_xfer;
    logic              fbk_xfer;

    fu_pkg::inst_id_t  held_id;
    fu_pkg::op_t       held_op;
    fu_pkg::reg_id_t   held_dst;
    fu_pkg::reg_id_t   held_src0;
    fu_pkg::reg_id_t   held_src1;
    fu_pkg::imm_t      held_imm;
    fu_pkg::reg_mask_t held_mask;

    // Feedback and hand-off to the result stage happen together
    assign read_fbk_rdy = stage_vld && exec_rdy;
    assign exec_vld     = stage_vld && read_fbk_vld;
    assign fbk_xfer     = read_fbk_vld && read_fbk_rdy;

    // A new request only goes out when the slot is free by the next edge
    assign stage_free   = !stage_vld || fbk_xfer;
    assign read_req_vld = head_vld && stage_free;
    assign head_rdy     = read_req_rdy && stage_free;
    assign req_xfer     = read_req_vld && read_req_rdy;

    assign read_reg0_id     = head_src_reg0;
    assign read_reg1_id     = head_src_reg1;
    assign write_reg_id_nxt = head_dst_reg;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_vld <= 1'b0;
        end else if (req_xfer) begin
            stage_vld <= 1'b1;
        end else if (fbk_xfer) begin
            stage_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_xfer) begin
            held_id   <= head_id;
            held_op   <= head_op;
            held_dst  <= head_dst_reg;
            held_src0 <= head_src_reg0;
            held_src1 <= head_src_reg1;
            held_imm  <= head_imm;
        end
    end

    alu alu_inst (
        .op     (held_op),
        .src0   (read_reg0_val),
        .src1   (read_reg1_val),
        .imm    (held_imm),
        .result (exec_val)
    );

    assign exec_id      = held_id;
    assign exec_dst_reg = held_dst;
    assign exec_addr    = read_reg0_val;

    // Sources of the held instruction stay pending until their values return
    assign held_mask = stage_vld ? ((fu_pkg::reg_mask_t'(1) << held_src0) |
                                    (fu_pkg::reg_mask_t'(1) << held_src1)) : '0;

    assign pending_read_mask = queue_pending_read | held_mask;
    assign busy              = stage_vld;

endmodule

`default_nettype wire

/* hdl/issue_queue.sv */
// In-order issue queue
`default_nettype none

module issue_queue (
    input  wire                   clk,
    input  wire                   rst_n,

    input  wire                   in_vld,
    output logic                  in_rdy,
    input  wire fu_pkg::inst_id_t in_id,
    input  wire fu_pkg::op_t      in_op,
    input  wire fu_pkg::reg_id_t  in_dst_reg,
    input  wire fu_pkg::reg_id_t  in_src_reg0,
    input  wire fu_pkg::reg_id_t  in_src_reg1,
    input  wire fu_pkg::imm_t     in_imm,

    output logic                  head_vld,
    input  wire                   head_rdy,
    output fu_pkg::inst_id_t      head_id,
    output fu_pkg::op_t           head_op,
    output fu_pkg::reg_id_t       head_dst_reg,
    output fu_pkg::reg_id_t       head_src_reg0,
    output fu_pkg::reg_id_t       head_src_reg1,
    output fu_pkg::imm_t          head_imm,

    output fu_pkg::reg_mask_t     pending_read,
    output logic                  empty
);

    fu_pkg::inst_id_t   entry_id   [fu_pkg::QUEUE_DEPTH];
    fu_pkg::op_t        entry_op   [fu_pkg::QUEUE_DEPTH];
    fu_pkg::reg_id_t    entry_dst  [fu_pkg::QUEUE_DEPTH];
    fu_pkg::reg_id_t    entry_src0 [fu_pkg::QUEUE_DEPTH];
    fu_pkg::reg_id_t    entry_src1 [fu_pkg::QUEUE_DEPTH];
    fu_pkg::imm_t       entry_imm  [fu_pkg::QUEUE_DEPTH];

    fu_pkg::queue_ptr_t wr_ptr;
    fu_pkg::queue_ptr_t rd_ptr;
    fu_pkg::queue_cnt_t count;

    logic               push;
    logic               pop;

    assign in_rdy   = count != fu_pkg::queue_cnt_t'(fu_pkg::QUEUE_DEPTH);
    assign empty    = count == '0;
    assign head_vld = !empty;

    assign push = in_vld && in_rdy;
    assign pop  = head_vld && head_rdy;

    assign head_id       = entry_id[rd_ptr];
    assign head_op       = entry_op[rd_ptr];
    assign head_dst_reg  = entry_dst[rd_ptr];
    assign head_src_reg0 = entry_src0[rd_ptr];
    assign head_src_reg1 = entry_src1[rd_ptr];
    assign head_imm      = entry_imm[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            entry_id[wr_ptr]   <= in_id;
            entry_op[wr_ptr]   <= in_op;
            entry_dst[wr_ptr]  <= in_dst_reg;
            entry_src0[wr_ptr] <= in_src_reg0;
            entry_src1[wr_ptr] <= in_src_reg1;
            entry_imm[wr_ptr]  <= in_imm;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entries between the head and head plus count are live
    always_comb begin
        fu_pkg::queue_ptr_t offset;
        pending_read = '0;
        for (int i = 0; i < fu_pkg::QUEUE_DEPTH; i++) begin
            offset = fu_pkg::queue_ptr_t'(i) - rd_ptr;
            if (fu_pkg::queue_cnt_t'(offset) < count) begin
                pending_read |= fu_pkg::reg_mask_t'(1) << entry_src0[i];
                pending_read |= fu_pkg::reg_mask_t'(1) << entry_src1[i];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/alu.sv */
// Binary operation datapath
`default_nettype none

module alu (
    input  wire fu_pkg::op_t      op,
    input  wire fu_pkg::reg_val_t src0,
    input  wire fu_pkg::reg_val_t src1,
    input  wire fu_pkg::imm_t     imm,
    output fu_pkg::reg_val_t      result
);

    logic shift_out;

    // Shift amounts at or above the data width flush every bit
    assign shift_out = src1 >= fu_pkg::reg_val_t'(fu_pkg::REG_BIT);

    always_comb begin
        case (op)
            fu_pkg::OP_ST: begin
                result = src1;
            end
            fu_pkg::OP_CMP_GT: begin
                result = fu_pkg::reg_val_t'(src0 > src1);
            end
            fu_pkg::OP_ADD_IMM: begin
                result = src0 + fu_pkg::reg_val_t'(imm);
            end
            fu_pkg::OP_ADD: begin
                result = src0 + src1;
            end
            fu_pkg::OP_SHL: begin
                result = shift_out ? '0 : src0 << src1;
            end
            fu_pkg::OP_SHR: begin
                result = shift_out ? '0 : src0 >> src1;
            end
            fu_pkg::OP_MUL: begin
                // Low half of the product
                result = src0 * src1;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/fu_pkg.sv */
// Functional unit package
`default_nettype none

package fu_pkg;

    // Register file geometry
    localparam int NUM_REG     = 8;
    localparam int REG_BIT     = 16;
    localparam int REG_ID_BIT  = 3;

    // Instruction fields
    localparam int IMM_BIT     = 4;
    localparam int INST_ID_BIT = 8;
    localparam int OP_BIT      = 3;

    // Issue queue sizing, depth must stay a power of two
    localparam int QUEUE_DEPTH   = 4;
    localparam int QUEUE_PTR_BIT = 2;

    // Opcodes, values 7 and up are reserved
    localparam logic [OP_BIT-1:0] OP_ST      = 3'd0;
    localparam logic [OP_BIT-1:0] OP_CMP_GT  = 3'd1;
    localparam logic [OP_BIT-1:0] OP_ADD_IMM = 3'd2;
    localparam logic [OP_BIT-1:0] OP_ADD     = 3'd3;
    localparam logic [OP_BIT-1:0] OP_SHL     = 3'd4;
    localparam logic [OP_BIT-1:0] OP_SHR     = 3'd5;
    localparam logic [OP_BIT-1:0] OP_MUL     = 3'd6;

    typedef logic [REG_BIT-1:0]     reg_val_t;
    typedef logic [REG_ID_BIT-1:0]  reg_id_t;

    // One bit per architectural register
    typedef logic [NUM_REG-1:0]     reg_mask_t;

    typedef logic [INST_ID_BIT-1:0] inst_id_t;
    typedef logic [IMM_BIT-1:0]     imm_t;
    typedef logic [OP_BIT-1:0]      op_t;

    // Queue pointer and occupancy count
    typedef logic [QUEUE_PTR_BIT-1:0] queue_ptr_t;
    typedef logic [QUEUE_PTR_BIT:0]   queue_cnt_t;

endpackage

`default_nettype wire
